// File: ep_pkg.sv
// --------------------------------------------------------------------------
// Endpoint register block definitions
// Local-link widths, register map, TLP header layouts and the register
// write and interrupt configuration bundles shared by all blocks
// --------------------------------------------------------------------------
package ep_pkg;

    // ----------------------------------------------------------------------
    // Widths and timing
    // ----------------------------------------------------------------------
    localparam int TRN_DATA_W = 64;                    // Local-link data
    localparam int TRN_REM_W  = 8;                     // Byte-valid remainder
    localparam int BAR_HIT_W  = 7;
    localparam int REG_ADDR_W = 4;                     // Doubleword index
    localparam int TIME_W     = 32;

    localparam logic [TIME_W-1:0] NS_PER_SEC = 32'd1_000_000_000;
    localparam int unsigned NS_PER_TICK_DEF  = 4;      // 250 MHz trn_clk

    localparam int REG_BAR_IDX = 2;                    // Register BAR hit bit
    localparam int NUM_IRQ_SRC = 2;                    // Receive, transmit

    // ----------------------------------------------------------------------
    // Register map, index taken from address bits 5:2
    // ----------------------------------------------------------------------
    localparam logic [REG_ADDR_W-1:0] REG_INT_EN     = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_INT_PERIOD = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_TIME_NSECS = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_TIME_SECS  = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_TS_EN      = 4'd4;
    localparam logic [REG_ADDR_W-1:0] REG_RX_RESEND  = 4'd5;
    localparam logic [REG_ADDR_W-1:0] REG_TX_RESEND  = 4'd6;

    // Memory write fmt/type bytes
    localparam logic [7:0] FMT_MWR_3DW = 8'h40;
    localparam logic [7:0] FMT_MWR_4DW = 8'h60;

    typedef struct packed {
        logic [7:0]  fmt_type;
        logic [13:0] tc_attr;                          // TC, TD, EP, attr, reserved
        logic [9:0]  length;                           // In doublewords
    } tlp_dw0_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } mwr32_qw_t;

    typedef struct packed {
        logic [31:0] addr_hi;
        logic [31:0] addr_lo;
    } mwr64_qw_t;

    // Second beat, layout depends on header size
    typedef union packed {
        mwr32_qw_t mwr32;
        mwr64_qw_t mwr64;
    } tlp_qw1_u;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] idx;
        logic [31:0]           data;
    } reg_wr_t;

    typedef struct packed {
        logic        en;
        logic [31:0] period;                           // Moderation, in cycles
    } int_cfg_t;

endpackage

// File: ep_vectors.txt
# name op a b c exp, all hex; wr3 wr4 wrbar a=index b=data c=length exp=ts_en
# evt a=event mask, rsd a=resend index, mod b=period, exp=irqs; tim a=ns b=s exp=s
idle_no_irq    evt   1        0  0 0
ts_set_3dw     wr3   4        1  1 1
ts_clr_4dw     wr4   4        0  1 0
ts_set_again   wr3   4        1  1 1
ts_wrong_bar   wrbar 4        0  1 1
ts_len2_3dw    wr3   4        0  2 1
ts_len2_4dw    wr4   4        0  2 1
int_enable     wr3   0        1  1 1
period_zero    wr4   1        0  1 1
rx_one_irq     evt   1        0  0 1
rx_tx_two_irq  evt   3        0  0 2
period_set     wr3   1        40 1 1
rx_moderated   mod   1        40 0 2
tx_resend      rsd   6        0  0 1
time_rollover  tim   3b9ac618 10 0 11

// File: interrupt_ctrl.sv
// --------------------------------------------------------------------------
// Interrupt control registers
// Global interrupt enable and moderation period, written by the host
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module interrupt_ctrl import ep_pkg::*; (
    input  logic     trn_clk,
    input  logic     arst_n,
    input  reg_wr_t  reg_wr,
    output int_cfg_t int_cfg
);

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            int_cfg <= '0;                          // Disabled, period 0
        end else if (reg_wr.valid) begin
            if (reg_wr.idx == REG_INT_EN) begin
                int_cfg.en <= reg_wr.data[0];
            end
            if (reg_wr.idx == REG_INT_PERIOD) begin
                int_cfg.period <= reg_wr.data;      // Cycles between interrupts
            end
        end
    end

endmodule

// File: irq_moderator.sv
// --------------------------------------------------------------------------
// Interrupt moderator, one per direction
// Events and resend writes set a pending flag, a request is raised once
// interrupts are enabled and the period has elapsed since the last grant
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module irq_moderator import ep_pkg::*; #(
    parameter logic [REG_ADDR_W-1:0] RESEND_REG = REG_RX_RESEND
) (
    input  logic     trn_clk,
    input  logic     arst_n,
    input  reg_wr_t  reg_wr,
    input  int_cfg_t int_cfg,
    input  logic     event_pulse,
    input  logic     grant,
    output logic     request
);

    logic        pending;
    logic        set_pend;
    logic        period_met;
    logic [31:0] timer;                             // Cycles since last grant

    assign set_pend   = event_pulse || (reg_wr.valid && reg_wr.idx == RESEND_REG);
    assign period_met = timer >= int_cfg.period;

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            timer   <= '0;
            request <= 1'b0;
        end else begin
            pending <= set_pend | (pending & ~grant);   // New event survives grant
            if (grant) begin
                timer   <= '0;                      // Moderation window restarts
                request <= 1'b0;
            end else begin
                if (timer != '1) begin
                    timer <= timer + 1'b1;          // Saturates
                end
                if (pending && int_cfg.en && period_met) begin
                    request <= 1'b1;                // Held until granted
                end
            end
        end
    end

    req_held: assert property (@(posedge trn_clk) disable iff (!arst_n)
        $fell(request) |-> $past(grant));

endmodule

// File: msi_arbiter.sv
// --------------------------------------------------------------------------
// Interrupt arbiter
// Round-robin merge of the source requests onto the core's legacy
// interrupt handshake, one source served at a time
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module msi_arbiter #(
    parameter int NUM_SRC = 2
) (
    input  logic               trn_clk,
    input  logic               arst_n,
    input  logic [NUM_SRC-1:0] request,
    input  logic               cfg_interrupt_rdy_n,
    output logic [NUM_SRC-1:0] grant,
    output logic               cfg_interrupt_n
);

    localparam int SEL_W = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

    typedef enum logic {S_IDLE, S_SERVE} arb_state_t;

    arb_state_t         state;
    logic [NUM_SRC-1:0] req_live;
    logic [SEL_W-1:0]   ptr;                        // Highest priority next
    logic [SEL_W-1:0]   sel;
    logic [SEL_W-1:0]   cur;                        // Source being served

    assign req_live = request & ~grant;             // Granted request still high

    // First live request at or after the pointer
    always_comb begin
        int idx;
        idx = 0;
        sel = ptr;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            idx = (int'(ptr) + i) % NUM_SRC;
            if (req_live[idx]) begin
                sel = SEL_W'(idx);
            end
        end
    end

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= S_IDLE;
            ptr             <= '0;                  // Receive first
            cur             <= '0;
            grant           <= '0;
            cfg_interrupt_n <= 1'b1;
        end else begin
            grant <= '0;
            case (state)
                S_IDLE: if (|req_live) begin
                    state           <= S_SERVE;
                    cur             <= sel;
                    cfg_interrupt_n <= 1'b0;
                end
                default: if (!cfg_interrupt_rdy_n) begin
                    state           <= S_IDLE;
                    grant           <= NUM_SRC'(1) << cur;
                    cfg_interrupt_n <= 1'b1;
                    ptr <= (cur == SEL_W'(NUM_SRC - 1)) ? '0 : cur + 1'b1;
                end
            endcase
        end
    end

    // Grant goes to at most one source, and only to one still requesting
    grant_onehot: assert property (@(posedge trn_clk) disable iff (!arst_n)
        $onehot0(grant) && (grant & ~request) == '0);

    line_held: assert property (@(posedge trn_clk) disable iff (!arst_n)
        !cfg_interrupt_n && cfg_interrupt_rdy_n |=> !cfg_interrupt_n);

endmodule

// File: pcie_ep_ctrl.sv
// --------------------------------------------------------------------------
// PCIe endpoint register and interrupt top level
// Host register writes from the receive local-link, system time and
// moderated receive/transmit interrupts on one legacy interrupt line
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module pcie_ep_ctrl import ep_pkg::*; #(
    parameter int unsigned NS_PER_TICK = NS_PER_TICK_DEF
) (
    input  logic                  trn_clk,
    input  logic                  arst_n,
    input  logic [TRN_DATA_W-1:0] trn_rd,
    input  logic [TRN_REM_W-1:0]  trn_rrem,
    input  logic                  trn_rsof_n,
    input  logic                  trn_reof_n,
    input  logic                  trn_rsrc_rdy_n,
    input  logic [BAR_HIT_W-1:0]  trn_rbar_hit_n,
    input  logic                  rx_activity,
    input  logic                  tx_done,
    input  logic                  cfg_interrupt_rdy_n,
    output logic                  cfg_interrupt_n,
    output logic [TIME_W-1:0]     sys_nsecs,
    output logic [TIME_W-1:0]     sys_secs,
    output logic                  rx_timestamp_en
);

    reg_wr_t                reg_wr;
    int_cfg_t               int_cfg;
    logic [NUM_IRQ_SRC-1:0] irq_req;                // Bit 0 receive, bit 1 transmit
    logic [NUM_IRQ_SRC-1:0] irq_grant;

    // ----------------------------------------------------------------------
    // Host register writes
    // ----------------------------------------------------------------------
    trn_wr_decoder trn_wr_decoder_mod (
        .trn_clk        (trn_clk),
        .arst_n         (arst_n),
        .trn_rd         (trn_rd),
        .trn_rrem       (trn_rrem),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .reg_wr         (reg_wr)
    );

    interrupt_ctrl interrupt_ctrl_mod (
        .trn_clk (trn_clk),
        .arst_n  (arst_n),
        .reg_wr  (reg_wr),
        .int_cfg (int_cfg)
    );

    sys_time #(
        .NS_PER_TICK (NS_PER_TICK)
    ) sys_time_mod (
        .trn_clk         (trn_clk),
        .arst_n          (arst_n),
        .reg_wr          (reg_wr),
        .sys_nsecs       (sys_nsecs),
        .sys_secs        (sys_secs),
        .rx_timestamp_en (rx_timestamp_en)
    );

    // ----------------------------------------------------------------------
    // Interrupt sources and the shared line
    // ----------------------------------------------------------------------
    irq_moderator #(
        .RESEND_REG (REG_RX_RESEND)
    ) rx_irq_moderator (
        .trn_clk     (trn_clk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .int_cfg     (int_cfg),
        .event_pulse (rx_activity),
        .grant       (irq_grant[0]),
        .request     (irq_req[0])
    );

    irq_moderator #(
        .RESEND_REG (REG_TX_RESEND)
    ) tx_irq_moderator (
        .trn_clk     (trn_clk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .int_cfg     (int_cfg),
        .event_pulse (tx_done),
        .grant       (irq_grant[1]),
        .request     (irq_req[1])
    );

    msi_arbiter #(
        .NUM_SRC (NUM_IRQ_SRC)
    ) msi_arbiter_mod (
        .trn_clk             (trn_clk),
        .arst_n              (arst_n),
        .request             (irq_req),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .grant               (irq_grant),
        .cfg_interrupt_n     (cfg_interrupt_n)
    );

endmodule

// File: project.f
ep_pkg.sv
trn_wr_decoder.sv
interrupt_ctrl.sv
sys_time.sv
irq_moderator.sv
msi_arbiter.sv
pcie_ep_ctrl.sv
tb_pcie_ep_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -f project.f --top-module tb_pcie_ep_ctrl -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
else
    exit 1
fi

// File: sys_time.sv
// --------------------------------------------------------------------------
// System time
// Free running seconds/nanoseconds clock, loadable by the host, plus the
// receive timestamp enable bit
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module sys_time import ep_pkg::*; #(
    parameter int unsigned NS_PER_TICK = NS_PER_TICK_DEF
) (
    input  logic              trn_clk,
    input  logic              arst_n,
    input  reg_wr_t           reg_wr,
    output logic [TIME_W-1:0] sys_nsecs,
    output logic [TIME_W-1:0] sys_secs,
    output logic              rx_timestamp_en
);

    logic [TIME_W-1:0] ns_sum;
    logic              wrap;
    logic              ld_ns;
    logic              ld_s;

    assign ns_sum = sys_nsecs + TIME_W'(NS_PER_TICK);
    assign wrap   = ns_sum >= NS_PER_SEC;           // Second boundary crossed
    assign ld_ns  = reg_wr.valid && reg_wr.idx == REG_TIME_NSECS;
    assign ld_s   = reg_wr.valid && reg_wr.idx == REG_TIME_SECS;

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            sys_nsecs       <= '0;
            sys_secs        <= '0;
            rx_timestamp_en <= 1'b0;
        end else begin
            if (ld_ns) begin
                sys_nsecs <= reg_wr.data;           // Load wins over count
            end else if (wrap) begin
                sys_nsecs <= ns_sum - NS_PER_SEC;
            end else begin
                sys_nsecs <= ns_sum;
            end
            if (ld_s) begin
                sys_secs <= reg_wr.data;
            end else if (wrap) begin
                sys_secs <= sys_secs + 1'b1;
            end
            if (reg_wr.valid && reg_wr.idx == REG_TS_EN) begin
                rx_timestamp_en <= reg_wr.data[0];
            end
        end
    end

    // Host loads are expected in range, so the wrap keeps it there
    nsecs_range: assert property (@(posedge trn_clk) disable iff (!arst_n)
        sys_nsecs < NS_PER_SEC);

endmodule

// File: tb_pcie_ep_ctrl.sv
// --------------------------------------------------------------------------
// Testbench for the endpoint register and interrupt block
// Replays the vector file as host TLP writes and events, answers the
// interrupt handshake and checks timestamp, interrupt and time behavior
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_pcie_ep_ctrl import ep_pkg::*; ();

    localparam logic [31:0] SEED = 32'hbaa4_be3d;

    logic              trn_clk;
    logic              arst_n;
    logic [63:0]       trn_rd;
    logic [7:0]        trn_rrem;
    logic              trn_rsof_n;
    logic              trn_reof_n;
    logic              trn_rsrc_rdy_n;
    logic [6:0]        trn_rbar_hit_n;
    logic              rx_activity;
    logic              tx_done;
    logic              cfg_interrupt_rdy_n;
    logic              cfg_interrupt_n;
    logic [31:0]       sys_nsecs;
    logic [31:0]       sys_secs;
    logic              rx_timestamp_en;
    logic [31:0]       drv_rng;                     // Beat gap generator
    logic [31:0]       rsp_rng;                     // Ready delay generator
    int                cyc = 0;
    int                irq_count = 0;
    int                prev_fall = 0;               // Cycle of previous line assertion
    int                last_fall = 0;

    pcie_ep_ctrl UUT (
        .trn_clk             (trn_clk),
        .arst_n              (arst_n),
        .trn_rd              (trn_rd),
        .trn_rrem            (trn_rrem),
        .trn_rsof_n          (trn_rsof_n),
        .trn_reof_n          (trn_reof_n),
        .trn_rsrc_rdy_n      (trn_rsrc_rdy_n),
        .trn_rbar_hit_n      (trn_rbar_hit_n),
        .rx_activity         (rx_activity),
        .tx_done             (tx_done),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .sys_nsecs           (sys_nsecs),
        .sys_secs            (sys_secs),
        .rx_timestamp_en     (rx_timestamp_en)
    );

    initial begin
        trn_clk = 1'b0;
        forever #20 trn_clk = ~trn_clk;             // 25 MHz bench clock
    end

    always @(posedge trn_clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic wait_irqs(input int target, input int limit, input string name);
        int n;
        n = 0;
        while (irq_count < target) begin
            if (n == limit) begin
                fail_run($sformatf("Timeout in %s, only %0d interrupts seen", name, irq_count));
            end
            @(negedge trn_clk);
            n++;
        end
    endtask

    task automatic wait_secs(input logic [31:0] target, input int limit, input string name);
        int n;
        n = 0;
        while (sys_secs != target) begin
            if (n == limit) begin
                fail_run($sformatf("Timeout in %s, seconds never reached %0h", name, target));
            end
            @(negedge trn_clk);
            n++;
        end
    endtask

    // Interrupt acknowledged once the line is released
    task automatic wait_line_idle(input int limit, input string name);
        int n;
        n = 0;
        while (!cfg_interrupt_n) begin
            if (n == limit) begin
                fail_run($sformatf("Timeout in %s, interrupt line never released", name));
            end
            @(negedge trn_clk);
            n++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Single memory write TLP, random idle gaps between beats
    // ----------------------------------------------------------------------
    task automatic send_wr(input bit is4, input bit good_bar, input logic [3:0] idx,
                           input logic [31:0] data, input logic [9:0] len);
        logic [31:0] dw[$];
        int          nbeats;
        int          gap;
        bit          odd;
        dw.push_back({is4 ? FMT_MWR_4DW : FMT_MWR_3DW, 14'h0, len});
        dw.push_back(32'h0100_000f);                // Requester, tag, byte enables
        if (is4) begin
            dw.push_back(32'h0);                    // Upper address
        end
        dw.push_back(32'hf000_0000 | (32'(idx) << 2));
        for (int k = 0; k < int'(len); k++) begin
            dw.push_back(data + 32'(k));
        end
        odd = (dw.size() % 2) == 1;
        if (odd) begin
            dw.push_back(32'h0);
        end
        nbeats = dw.size() / 2;
        for (int k = 0; k < nbeats; k++) begin
            gap     = int'((drv_rng >> 16) % 3);
            drv_rng = lcg_next(drv_rng);
            trn_rsrc_rdy_n = 1'b1;
            trn_rsof_n     = 1'b1;
            trn_reof_n     = 1'b1;
            repeat (gap) @(negedge trn_clk);
            trn_rd         = {dw[2*k], dw[2*k+1]};  // Earlier DW in the high half
            trn_rsof_n     = (k != 0);
            trn_reof_n     = (k != nbeats - 1);
            trn_rrem       = (k == nbeats - 1 && odd) ? 8'hf0 : 8'hff;
            trn_rbar_hit_n = good_bar ? 7'h7b : 7'h7e;  // BAR 2 or BAR 0
            trn_rsrc_rdy_n = 1'b0;
            @(negedge trn_clk);
        end
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    task automatic pulse_events(input logic [1:0] mask);
        rx_activity = mask[0];
        tx_done     = mask[1];
        @(negedge trn_clk);
        rx_activity = 1'b0;
        tx_done     = 1'b0;
    endtask

    task automatic run_test(input string name, input string op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] c,
                            input logic [31:0] exp);
        int base;
        base = irq_count;
        case (op)
            "wr3", "wr4", "wrbar": begin
                send_wr(op == "wr4", op != "wrbar", a[3:0], b, c[9:0]);
                repeat (4) @(negedge trn_clk);      // Strobe, then register update
                check(name, exp, 32'(rx_timestamp_en));
            end
            "evt", "rsd": begin
                if (op == "evt") begin
                    pulse_events(a[1:0]);
                end else begin
                    send_wr(1'b0, 1'b1, a[3:0], 32'h1, 10'd1);
                end
                wait_irqs(base + int'(exp), 500, name);
                repeat (200) @(negedge trn_clk);    // Nothing extra may follow
                check(name, exp, 32'(irq_count - base));
            end
            "mod": begin
                pulse_events(2'b01);
                wait_irqs(base + 1, 500, name);
                wait_line_idle(500, name);          // First one granted
                pulse_events(2'b01);                // Lands inside the moderation window
                wait_irqs(base + int'(exp), 500 + int'(b), name);
                check(name, 32'h1, 32'((last_fall - prev_fall) >= int'(b)));
            end
            "tim": begin
                send_wr(1'b0, 1'b1, REG_TIME_SECS, b, 10'd1);
                send_wr(1'b0, 1'b1, REG_TIME_NSECS, a, 10'd1);
                wait_secs(exp, 1000, name);
                check(name, 32'h1, 32'(sys_nsecs < 32'd1_000_000_000));
                repeat (250) begin
                    @(negedge trn_clk);
                    check(name, exp, sys_secs);     // No second rollover yet
                end
            end
            default: fail_run($sformatf("Unknown operation %s in test %s", op, name));
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Interrupt responder, ready after a random delay
    // ----------------------------------------------------------------------
    initial begin
        int   wait_cnt;
        logic busy;
        cfg_interrupt_rdy_n = 1'b1;
        rsp_rng  = lcg_next(SEED);
        busy     = 1'b0;
        wait_cnt = 0;
        forever begin
            @(negedge trn_clk);
            if (!cfg_interrupt_rdy_n) begin
                cfg_interrupt_rdy_n = 1'b1;         // Ready lasts one cycle
            end else if (!cfg_interrupt_n) begin
                if (!busy) begin
                    busy      = 1'b1;
                    irq_count <= irq_count + 1;
                    prev_fall <= last_fall;
                    last_fall <= cyc;
                    wait_cnt  = int'((rsp_rng >> 16) % 5);
                    rsp_rng   = lcg_next(rsp_rng);
                end
                if (wait_cnt == 0) begin
                    cfg_interrupt_rdy_n = 1'b0;
                    busy                = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    initial begin
        int          fd;
        int          n;
        int          ntests;
        string       line;
        string       name;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] exp;
        arst_n         = 1'b0;
        trn_rd         = '0;
        trn_rrem       = 8'hff;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        rx_activity    = 1'b0;
        tx_done        = 1'b0;
        drv_rng        = SEED;
        ntests         = 0;
        repeat (16) @(negedge trn_clk);
        arst_n = 1'b1;
        @(negedge trn_clk);
        check("reset_irq_line", 32'h1, 32'(cfg_interrupt_n));
        check("reset_ts_en", 32'h0, 32'(rx_timestamp_en));
        check("reset_secs", 32'h0, sys_secs);
        fd = $fopen("ep_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the vector file ep_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, exp);
            if (n == 6) begin                       // Comment lines fall out here
                run_test(name, op, a, b, c, exp);
                ntests++;
            end
        end
        $fclose(fd);
        check("vector_count", 32'h1, 32'(ntests > 0));
        $display("No errors");
        $finish;
    end

endmodule

// File: trn_wr_decoder.sv
// --------------------------------------------------------------------------
// Receive local-link write decoder
// Picks single-doubleword memory writes to the register BAR out of the
// TLP stream and turns them into one-cycle register write strobes
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module trn_wr_decoder import ep_pkg::*; (
    input  logic                  trn_clk,
    input  logic                  arst_n,
    input  logic [TRN_DATA_W-1:0] trn_rd,
    input  logic [TRN_REM_W-1:0]  trn_rrem,        // Byte valid, FF or F0 on EOF
    input  logic                  trn_rsof_n,
    input  logic                  trn_reof_n,
    input  logic                  trn_rsrc_rdy_n,
    input  logic [BAR_HIT_W-1:0]  trn_rbar_hit_n,
    output reg_wr_t               reg_wr
);

    typedef enum logic [1:0] {
        S_IDLE,                                     // Between packets
        S_HDR,                                      // Header rejected, drain to EOF
        S_ADDR,                                     // Beat 1 expected
        S_DATA                                      // Beat 2 of 4DW write
    } dec_state_t;

    dec_state_t            state;
    logic                  beat;
    logic                  hdr_ok;
    logic                  is_4dw;
    logic                  wr_valid;
    logic [REG_ADDR_W-1:0] wr_idx;
    logic [31:0]           wr_data;
    tlp_dw0_t              dw0;
    tlp_qw1_u              qw1;

    assign beat = ~trn_rsrc_rdy_n;
    assign dw0  = trn_rd[63:32];                    // First header DW sits high
    assign qw1  = trn_rd;

    // Memory write, one DW, register BAR, more beats to come
    assign hdr_ok = (dw0.fmt_type == FMT_MWR_3DW || dw0.fmt_type == FMT_MWR_4DW)
                    && dw0.length == 10'd1
                    && ~trn_rbar_hit_n[REG_BAR_IDX]
                    && trn_reof_n;

    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            is_4dw   <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;                       // Strobe by default
            if (beat) begin
                case (state)
                    S_IDLE: if (!trn_rsof_n && trn_reof_n) begin
                        state  <= hdr_ok ? S_ADDR : S_HDR;
                        is_4dw <= dw0.fmt_type == FMT_MWR_4DW;
                    end
                    S_ADDR: if (!trn_reof_n) begin
                        state    <= S_IDLE;
                        wr_valid <= ~is_4dw & (&trn_rrem[3:0]); // Data DW in low half
                    end else begin
                        state <= is_4dw ? S_DATA : S_HDR;
                    end
                    S_DATA: if (!trn_reof_n) begin
                        state    <= S_IDLE;
                        wr_valid <= &trn_rrem[7:4];         // Data DW in high half
                    end else begin
                        state <= S_HDR;                     // Too long, drop it
                    end
                    default: if (!trn_reof_n) begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // Index and data, no byte swap
    always_ff @(posedge trn_clk) begin
        if (beat && state == S_ADDR) begin
            wr_idx  <= is_4dw ? qw1.mwr64.addr_lo[5:2] : qw1.mwr32.addr[5:2];
            wr_data <= qw1.mwr32.data;
        end else if (beat && state == S_DATA) begin
            wr_data <= trn_rd[63:32];
        end
    end

    assign reg_wr = '{valid: wr_valid, idx: wr_idx, data: wr_data};

    // A new frame must not start before the previous one ended
    sof_in_packet: assert property (@(posedge trn_clk) disable iff (!arst_n)
        beat && state != S_IDLE |-> trn_rsof_n);

endmodule
